//--- Makefile
# Verilator flow for the matching stage

VERILATOR ?= verilator
TOP       ?= matchingStageTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= ** FAIL **
JOBS      ?= 0
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
rtl/tokenPkg.sv
rtl/matchMemPkg.sv
rtl/matchMemory.sv
rtl/operandPairer.sv
rtl/matchCtrl.sv
rtl/matchingStage.sv
testbench/clockGen.sv
testbench/matchingStageTb.sv

//--- rtl/matchCtrl.sv
`timescale 1ns/1ps

module matchCtrl (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  tokenPkg::colorT       inColor,
    input  tokenPkg::genT         inGen,
    input  tokenPkg::destT        inDest,
    input  logic                  inC,
    input  logic                  inZ,
    input  tokenPkg::opKindT      inKind,
    input  tokenPkg::dataT        inData,
    input  logic                  rdValid,
    input  matchMemPkg::matchTagT rdTag,
    input  logic                  rdSide,
    input  logic                  outBusy,
    output logic                  inReady,
    output matchMemPkg::memAddrT  memAddr,
    output logic                  memRdEn,
    output logic                  memWrEn,
    output logic                  memDelEn,
    output matchMemPkg::matchTagT wrTag,
    output logic                  wrSide,
    output tokenPkg::dataT        wrData,
    output logic                  emitEn,
    output matchMemPkg::emitModeT emitMode,
    output tokenPkg::colorT       tokColor,
    output tokenPkg::genT         tokGen,
    output tokenPkg::destT        tokDest,
    output logic                  tokC,
    output logic                  tokZ,
    output tokenPkg::opKindT      tokKind,
    output tokenPkg::dataT        tokData
);

    import tokenPkg::*;
    import matchMemPkg::*;

    ctrlStateT state;
    emitModeT  modeQ;
    logic      runEn;

    // Accepted token packed as it arrived
    logic [TOKEN_W-1:0] tokReg;
    logic [KIND_W-1:0]  kindBits;

    matchTagT curTag;
    logic     curSide;
    logic     accept;
    logic     inBypass;
    logic     isPair;

    assign accept   = inValid && inReady;
    assign inBypass = (inKind == OP_CONST) || (inKind == OP_RSVD);

    // Held for the whole life of the token
    assign {tokColor, tokGen, tokDest, tokC, tokZ, kindBits, tokData} = tokReg;
    assign tokKind = opKindT'(kindBits);

    assign curTag  = {tokColor, tokGen, tokDest};
    assign curSide = (tokKind == OP_LEFT);

    // Slot hash over the key fields
    assign memAddr = tokDest[5:0] ^ tokGen[5:0] ^ {tokColor, 3'b000};

    // Partner of the other side with the same key
    assign isPair = rdValid && (rdTag == curTag) && (rdSide != curSide);

    // Ready rises one cycle after reset ends
    always_ff @(posedge clk) begin
        if (!rstN) begin
            runEn <= 1'b0;
        end else begin
            runEn <= 1'b1;
        end
    end

    assign inReady = runEn && (state == IDLE) && !outBusy;

    always_ff @(posedge clk) begin
        if (accept) begin
            tokReg <= {inColor, inGen, inDest, inC, inZ, inKind, inData};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            modeQ <= EMIT_BYPASS;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (inBypass) begin
                            state <= EMIT;
                            modeQ <= EMIT_BYPASS;
                        end else begin
                            state <= LOOKUP;
                        end
                    end
                end
                LOOKUP: state <= RESOLVE;
                RESOLVE: begin
                    // Empty slot stores and returns to idle without output
                    if (!rdValid) begin
                        state <= IDLE;
                    end else begin
                        state <= EMIT;
                        modeQ <= isPair ? EMIT_PAIR : EMIT_RETRY;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Memory commands
    assign memRdEn  = (state == LOOKUP);
    assign memWrEn  = (state == RESOLVE) && !rdValid;
    assign memDelEn = (state == RESOLVE) && isPair;
    assign wrTag    = curTag;
    assign wrSide   = curSide;
    assign wrData   = tokData;

    assign emitEn   = (state == EMIT);
    assign emitMode = modeQ;

endmodule

//--- rtl/matchMemPkg.sv
package matchMemPkg;

    // Matching store geometry
    localparam int MEM_DEPTH = 64;
    localparam int ADDR_W    = 6;

    // Key is color, gen and dest
    localparam int TAG_W     = 18;

    typedef logic [ADDR_W-1:0] memAddrT;
    typedef logic [TAG_W-1:0]  matchTagT;

    // Control FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        RESOLVE = 2'd2,
        EMIT    = 2'd3
    } ctrlStateT;

    // What the pairer builds from the latched token
    typedef enum logic [1:0] {
        EMIT_PAIR   = 2'd0,
        EMIT_BYPASS = 2'd1,
        EMIT_RETRY  = 2'd2
    } emitModeT;

endpackage

//--- rtl/matchMemory.sv
`timescale 1ns/1ps

module matchMemory (
    input  logic                 clk,
    input  logic                 rstN,
    input  matchMemPkg::memAddrT memAddr,
    input  logic                 memRdEn,
    input  logic                 memWrEn,
    input  logic                 memDelEn,
    input  matchMemPkg::matchTagT wrTag,
    input  logic                 wrSide,
    input  tokenPkg::dataT       wrData,
    output logic                 rdValid,
    output matchMemPkg::matchTagT rdTag,
    output logic                 rdSide,
    output tokenPkg::dataT       rdData
);

    import tokenPkg::*;
    import matchMemPkg::*;

    // Entry storage
    matchTagT tagMem  [MEM_DEPTH];
    logic     sideMem [MEM_DEPTH];
    dataT     dataMem [MEM_DEPTH];

    // One occupancy bit per slot
    logic [MEM_DEPTH-1:0] validBits;

    // Entry write and registered read of the payload
    always_ff @(posedge clk) begin
        if (memWrEn) begin
            tagMem[memAddr]  <= wrTag;
            sideMem[memAddr] <= wrSide;
            dataMem[memAddr] <= wrData;
        end
        if (memRdEn) begin
            rdTag  <= tagMem[memAddr];
            rdSide <= sideMem[memAddr];
            rdData <= dataMem[memAddr];
        end
    end

    // Occupancy bits follow write and delete
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
        end else begin
            if (memWrEn) begin
                validBits[memAddr] <= 1'b1;
            end else if (memDelEn) begin
                validBits[memAddr] <= 1'b0;
            end
        end
    end

    // Read hit flag registered with the entry
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdValid <= 1'b0;
        end else if (memRdEn) begin
            rdValid <= validBits[memAddr];
        end
    end

endmodule

//--- rtl/matchingStage.sv
`timescale 1ns/1ps

module matchingStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    output logic             inReady,
    input  tokenPkg::colorT  inColor,
    input  tokenPkg::genT    inGen,
    input  tokenPkg::destT   inDest,
    input  logic             inC,
    input  logic             inZ,
    input  tokenPkg::opKindT inKind,
    input  tokenPkg::dataT   inData,
    output logic             outValid,
    input  logic             outReady,
    output tokenPkg::colorT  outColor,
    output tokenPkg::genT    outGen,
    output tokenPkg::destT   outDest,
    output logic             outC,
    output logic             outZ,
    output tokenPkg::dataT   outDataL,
    output tokenPkg::dataT   outDataR,
    output logic             outRetry
);

    import tokenPkg::*;
    import matchMemPkg::*;

    // Control to memory
    memAddrT  memAddr;
    logic     memRdEn;
    logic     memWrEn;
    logic     memDelEn;
    matchTagT wrTag;
    logic     wrSide;
    dataT     wrData;

    // Memory read port
    logic     rdValid;
    matchTagT rdTag;
    logic     rdSide;
    dataT     rdData;

    // Control to pairer
    logic     emitEn;
    emitModeT emitMode;
    colorT    tokColor;
    genT      tokGen;
    destT     tokDest;
    logic     tokC;
    logic     tokZ;
    opKindT   tokKind;
    dataT     tokData;
    logic     outBusy;

    matchCtrl uCtrl (
        .clk(clk), .rstN(rstN),
        .inValid(inValid), .inColor(inColor), .inGen(inGen), .inDest(inDest),
        .inC(inC), .inZ(inZ), .inKind(inKind), .inData(inData),
        .rdValid(rdValid), .rdTag(rdTag), .rdSide(rdSide), .outBusy(outBusy),
        .inReady(inReady), .memAddr(memAddr), .memRdEn(memRdEn),
        .memWrEn(memWrEn), .memDelEn(memDelEn),
        .wrTag(wrTag), .wrSide(wrSide), .wrData(wrData),
        .emitEn(emitEn), .emitMode(emitMode),
        .tokColor(tokColor), .tokGen(tokGen), .tokDest(tokDest),
        .tokC(tokC), .tokZ(tokZ), .tokKind(tokKind), .tokData(tokData)
    );

    matchMemory uMem (
        .clk(clk), .rstN(rstN),
        .memAddr(memAddr), .memRdEn(memRdEn), .memWrEn(memWrEn), .memDelEn(memDelEn),
        .wrTag(wrTag), .wrSide(wrSide), .wrData(wrData),
        .rdValid(rdValid), .rdTag(rdTag), .rdSide(rdSide), .rdData(rdData)
    );

    operandPairer uPairer (
        .clk(clk), .rstN(rstN),
        .emitEn(emitEn), .emitMode(emitMode),
        .tokColor(tokColor), .tokGen(tokGen), .tokDest(tokDest),
        .tokC(tokC), .tokZ(tokZ), .tokKind(tokKind), .tokData(tokData),
        .partnerData(rdData), .outReady(outReady), .outBusy(outBusy),
        .outValid(outValid), .outColor(outColor), .outGen(outGen), .outDest(outDest),
        .outC(outC), .outZ(outZ), .outDataL(outDataL), .outDataR(outDataR),
        .outRetry(outRetry)
    );

endmodule

//--- rtl/operandPairer.sv
`timescale 1ns/1ps

module operandPairer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  emitEn,
    input  matchMemPkg::emitModeT emitMode,
    input  tokenPkg::colorT       tokColor,
    input  tokenPkg::genT         tokGen,
    input  tokenPkg::destT        tokDest,
    input  logic                  tokC,
    input  logic                  tokZ,
    input  tokenPkg::opKindT      tokKind,
    input  tokenPkg::dataT        tokData,
    input  tokenPkg::dataT        partnerData,
    input  logic                  outReady,
    output logic                  outBusy,
    output logic                  outValid,
    output tokenPkg::colorT       outColor,
    output tokenPkg::genT         outGen,
    output tokenPkg::destT        outDest,
    output logic                  outC,
    output logic                  outZ,
    output tokenPkg::dataT        outDataL,
    output tokenPkg::dataT        outDataR,
    output logic                  outRetry
);

    import tokenPkg::*;
    import matchMemPkg::*;

    dataT nextDataL;
    dataT nextDataR;
    logic nextRetry;

    // Operand placement per emit mode
    always_comb begin
        nextDataL = tokData;
        nextDataR = '0;
        nextRetry = 1'b0;
        case (emitMode)
            EMIT_PAIR: begin
                // Left data always on DataL whichever side arrived first
                if (tokKind == OP_LEFT) begin
                    nextDataL = tokData;
                    nextDataR = partnerData;
                end else begin
                    nextDataL = partnerData;
                    nextDataR = tokData;
                end
            end
            EMIT_RETRY: nextRetry = 1'b1;
            default: nextRetry = 1'b0;
        endcase
    end

    // Output payload held until the transfer
    always_ff @(posedge clk) begin
        if (emitEn) begin
            outColor <= tokColor;
            outGen   <= tokGen;
            outDest  <= tokDest;
            outC     <= tokC;
            outZ     <= tokZ;
            outDataL <= nextDataL;
            outDataR <= nextDataR;
            outRetry <= nextRetry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (emitEn) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // Busy for as long as a token sits in the output register
    assign outBusy = outValid;

endmodule

//--- rtl/tokenPkg.sv
package tokenPkg;

    // Field widths of one token
    localparam int COLOR_W = 3;
    localparam int GEN_W   = 8;
    localparam int DEST_W  = 7;
    localparam int KIND_W  = 2;
    localparam int DATA_W  = 16;

    // Packed order is color, gen, dest, C, Z, kind, data
    localparam int TOKEN_W = COLOR_W + GEN_W + DEST_W + 2 + KIND_W + DATA_W;

    typedef logic [COLOR_W-1:0] colorT;
    typedef logic [GEN_W-1:0]   genT;
    typedef logic [DEST_W-1:0]  destT;
    typedef logic [DATA_W-1:0]  dataT;

    // Operand kind carried in every token
    typedef enum logic [KIND_W-1:0] {
        OP_RIGHT = 2'b00,
        OP_RSVD  = 2'b01,   // Bypasses matching like a constant
        OP_CONST = 2'b10,
        OP_LEFT  = 2'b11
    } opKindT;

endpackage

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 3;

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held low over the first three rising edges
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- testbench/matchVectors.txt
// Input: color_gen_dest_C_Z_kind_data, then output flag (1 = output expected)
// Expected: color_gen_dest_C_Z_dataL_dataR_retry (zero when no output)
// Kind: 0 right, 1 reserved, 2 constant, 3 left
0_01_05_0_0_3_1111_0_0_00_00_0_0_0000_0000_0
0_01_05_1_0_0_2222_1_0_01_05_1_0_1111_2222_0
1_10_20_0_1_0_3333_0_0_00_00_0_0_0000_0000_0
1_10_20_0_0_3_4444_1_1_10_20_0_0_4444_3333_0
2_03_11_0_0_3_5555_0_0_00_00_0_0_0000_0000_0
3_22_33_1_1_2_6666_1_3_22_33_1_1_6666_0000_0
0_44_55_0_0_1_7777_1_0_44_55_0_0_7777_0000_0
2_03_11_0_1_0_8888_1_2_03_11_0_1_5555_8888_0
0_01_05_0_0_3_9999_0_0_00_00_0_0_0000_0000_0
0_00_04_0_0_0_AAAA_1_0_00_04_0_0_AAAA_0000_1
0_01_05_1_0_3_BBBB_1_0_01_05_1_0_BBBB_0000_1
0_01_05_1_1_0_CCCC_1_0_01_05_1_1_9999_CCCC_0
0_01_05_0_0_3_DDDD_0_0_00_00_0_0_0000_0000_0
0_01_05_0_0_0_EEEE_1_0_01_05_0_0_DDDD_EEEE_0
1_10_20_0_0_0_0F0F_0_0_00_00_0_0_0000_0000_0
1_10_20_1_0_3_F0F0_1_1_10_20_1_0_F0F0_0F0F_0
0_00_00_0_0_3_1234_0_0_00_00_0_0_0000_0000_0
1_00_08_0_1_3_5678_1_1_00_08_0_1_5678_0000_1
1_00_08_0_0_0_9ABC_1_1_00_08_0_0_9ABC_0000_1
7_FF_7F_1_1_2_FFFF_1_7_FF_7F_1_1_FFFF_0000_0
0_00_00_0_1_0_4321_1_0_00_00_0_1_1234_4321_0
5_AA_2A_0_0_0_0001_0_0_00_00_0_0_0000_0000_0
5_AA_2A_1_1_0_0002_1_5_AA_2A_1_1_0002_0000_1
5_AA_2A_1_0_3_0003_1_5_AA_2A_1_0_0003_0001_0
6_12_34_0_1_1_ABCD_1_6_12_34_0_1_ABCD_0000_0
4_80_40_0_0_2_0000_1_4_80_40_0_0_0000_0000_0
3_3C_3C_0_0_3_BEEF_0_0_00_00_0_0_0000_0000_0
3_3D_3D_1_0_3_CAFE_1_3_3D_3D_1_0_CAFE_0000_1
3_3C_3C_1_1_0_0BAD_1_3_3C_3C_1_1_BEEF_0BAD_0
2_03_11_0_0_3_1357_0_0_00_00_0_0_0000_0000_0

//--- testbench/matchingStageTb.sv
`timescale 1ns/1ps

module matchingStageTb;

    import tokenPkg::*;

    localparam int NUM_VEC        = 30;
    localparam int RESET_CYCLES   = 3;
    localparam int CYCLES_PER_VEC = 40;
    localparam int MAX_CYCLES     = NUM_VEC * CYCLES_PER_VEC + RESET_CYCLES;
    localparam int DRAIN_CYCLES   = 8;

    logic   clk;
    logic   rstN;
    logic   inValid;
    logic   inReady;
    colorT  inColor;
    genT    inGen;
    destT   inDest;
    logic   inC;
    logic   inZ;
    opKindT inKind;
    dataT   inData;
    logic   outValid;
    logic   outReady;
    colorT  outColor;
    genT    outGen;
    destT   outDest;
    logic   outC;
    logic   outZ;
    dataT   outDataL;
    dataT   outDataR;
    logic   outRetry;

    // Input token, output flag, expected output token
    logic [115:0] vecMem [NUM_VEC];
    logic [63:0]  expQueue [$];
    logic [63:0]  expWord;
    logic [52:0]  curOut;
    logic [52:0]  heldOut;
    logic         holding = 1'b0;

    integer seed = 78985;
    int errorCount = 0;
    int checkCount = 0;
    int outCount = 0;
    int sentCount = 0;
    int cycleCount = 0;

    clockGen clockGenInst (.clk(clk), .rstN(rstN));

    matchingStage UUT (
        .clk(clk), .rstN(rstN),
        .inValid(inValid), .inReady(inReady),
        .inColor(inColor), .inGen(inGen), .inDest(inDest),
        .inC(inC), .inZ(inZ), .inKind(inKind), .inData(inData),
        .outValid(outValid), .outReady(outReady),
        .outColor(outColor), .outGen(outGen), .outDest(outDest),
        .outC(outC), .outZ(outZ), .outDataL(outDataL), .outDataR(outDataR),
        .outRetry(outRetry)
    );

    assign curOut = {outColor, outGen, outDest, outC, outZ, outDataL, outDataR, outRetry};

    task automatic checkField(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Field positions follow the column layout of the vector file
    task automatic compareOutput(input logic [63:0] expected);
        checkField("outColor", 16'(outColor), 16'(expected[62:60]));
        checkField("outGen", 16'(outGen), 16'(expected[59:52]));
        checkField("outDest", 16'(outDest), 16'(expected[50:44]));
        checkField("outC", 16'(outC), 16'(expected[40]));
        checkField("outZ", 16'(outZ), 16'(expected[36]));
        checkField("outDataL", outDataL, expected[35:20]);
        checkField("outDataR", outDataR, expected[19:4]);
        checkField("outRetry", 16'(outRetry), 16'(expected[0]));
    endtask

    task automatic sendToken(input logic [115:0] vec);
        @(negedge clk);
        inColor = vec[114:112];
        inGen   = vec[111:104];
        inDest  = vec[102:96];
        inC     = vec[92];
        inZ     = vec[88];
        inKind  = opKindT'(vec[85:84]);
        inData  = vec[83:68];
        inValid = 1'b1;
        if (vec[64]) begin
            expQueue.push_back(vec[63:0]);
        end
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        sentCount++;
    endtask

    task automatic finishRun();
        if (expQueue.size() > 0) begin
            errorCount++;
            $display("%0d expected output tokens never came out", expQueue.size());
        end
        $display("Tokens sent %0d, outputs %0d, checks %0d, errors %0d",
                 sentCount, outCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin : stimulus
        int i;
        $timeformat(-9, 0, " ns", 0);
        inValid = 1'b0;
        inColor = '0;
        inGen   = '0;
        inDest  = '0;
        inC     = 1'b0;
        inZ     = 1'b0;
        inKind  = OP_RIGHT;
        inData  = '0;
        $readmemh("testbench/matchVectors.txt", vecMem);
        if ($isunknown(vecMem[NUM_VEC-1])) begin
            errorCount++;
            $display("Vector file testbench/matchVectors.txt is missing or too short");
            finishRun();
        end else begin
            wait (rstN === 1'b1);
            for (i = 0; i < NUM_VEC; i++) begin
                sendToken(vecMem[i]);
            end
            @(negedge clk);
            inValid = 1'b0;
            while (expQueue.size() > 0) begin
                @(posedge clk);
            end
            // Catch any stray output after the last expected one
            repeat (DRAIN_CYCLES) @(posedge clk);
            finishRun();
        end
    end

    // Random back-pressure with one stall length per output token
    initial begin : stallDriver
        int stallLeft;
        logic stallArmed;
        outReady = 1'b1;
        stallLeft = 0;
        stallArmed = 1'b0;
        forever begin
            @(negedge clk);
            if (!outValid) begin
                stallArmed = 1'b0;
                outReady = 1'b1;
            end else begin
                if (!stallArmed) begin
                    stallLeft = $random(seed) & 3;
                    stallArmed = 1'b1;
                end
                if (stallLeft > 0) begin
                    outReady = 1'b0;
                    stallLeft--;
                end else begin
                    outReady = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstN && outValid && outReady) begin
            if (expQueue.size() == 0) begin
                errorCount++;
                $display("Output token at %0t came out with none expected", $time);
            end else begin
                expWord = expQueue.pop_front();
                compareOutput(expWord);
                outCount++;
            end
        end
        // Stalled token must stay put
        if (rstN && holding) begin
            assert (outValid === 1'b1) else begin
                errorCount++;
                $display("[FAIL] %0t outValid got %b expected 1", $time, outValid);
            end
            assert (curOut === heldOut) else begin
                errorCount++;
                $display("[FAIL] %0t held output fields got %h expected %h",
                         $time, curOut, heldOut);
            end
        end
        if (rstN && outValid && !outReady) begin
            assert (inReady === 1'b0) else begin
                errorCount++;
                $display("[FAIL] %0t inReady got %b expected 0", $time, inReady);
            end
            holding = 1'b1;
            heldOut = curOut;
        end else begin
            holding = 1'b0;
        end
    end

    initial begin : watchdog
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        errorCount++;
        $display("Timeout after %0d cycles, the stage stopped moving tokens", cycleCount);
        finishRun();
    end

endmodule
